//--- logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

  localparam int WINDOW_MAX = 16;  // largest reorder window a tag can address

  typedef logic [$clog2(WINDOW_MAX)-1:0] tag_t;

  // base integer ops, picked from funct3 plus funct7[5]
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // RV32M ops, value equals funct3
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } md_op_e;

  typedef struct packed {
    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic [31:0] a;
    logic [31:0] b;
  } issue_t;

  typedef struct packed {
    tag_t        tag;
    alu_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
  } alu_req_t;

  typedef struct packed {
    tag_t        tag;
    md_op_e      op;
    logic [31:0] a;
    logic [31:0] b;
  } md_req_t;

  typedef struct packed {
    tag_t        tag;
    logic [31:0] value;
  } result_t;

endpackage

`default_nettype wire

//--- logic/credit_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
  parameter int  DEPTH  = 4,
  parameter type item_t = logic [31:0]
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  push,
  input  item_t push_data,
  input  logic  pop,
  output item_t pop_data,
  output logic  empty,
  output logic  full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  item_t         mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  assign empty    = (count == '0);
  assign full     = (count == CW'(DEPTH));
  assign pop_data = mem[rd_ptr];  // head is visible without a read cycle

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(push) - CW'(pop);
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/issue_router.sv
`timescale 1ns/10ps
`default_nettype none

module issue_router import exec_pkg::*; #(
  parameter int IN_DEPTH = 4,
  parameter int WINDOW   = 8
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  issue_t   in_op,
  output logic     in_credit,
  input  logic     slot_free,
  output logic     alloc,
  output tag_t     alloc_tag,
  output logic     alu_push,
  output alu_req_t alu_req,
  input  logic     alu_full,
  output logic     md_push,
  output md_req_t  md_req,
  input  logic     md_full
);

  issue_t  head;
  logic    empty;
  logic    full;
  logic    is_md;
  logic    dispatch;
  alu_op_e alu_op;
  tag_t    next_tag;

  // upstream only sends against a credit, so full is never hit on push
  credit_fifo #(.DEPTH(IN_DEPTH), .item_t(issue_t)) u_issue_q (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (in_valid),
    .push_data(in_op),
    .pop      (dispatch),
    .pop_data (head),
    .empty    (empty),
    .full     (full)
  );

  assign is_md = (head.funct7 == 7'b0000001);

  always_comb begin
    alu_op = ALU_ADD;
    case (head.funct3)
      3'b000: alu_op = (head.funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
      3'b001: alu_op = ALU_SLL;
      3'b010: alu_op = ALU_SLT;
      3'b011: alu_op = ALU_SLTU;
      3'b100: alu_op = ALU_XOR;
      3'b101: alu_op = (head.funct7 == 7'b0100000) ? ALU_SRA : ALU_SRL;
      3'b110: alu_op = ALU_OR;
      3'b111: alu_op = ALU_AND;
      default: alu_op = ALU_ADD;
    endcase
  end

  // head leaves only when its reorder slot is idle and the lane has room
  assign dispatch  = !empty && slot_free && !(is_md ? md_full : alu_full);
  assign alloc     = dispatch;
  assign alloc_tag = next_tag;
  assign alu_push  = dispatch && !is_md;
  assign md_push   = dispatch && is_md;
  assign alu_req   = '{tag: next_tag, op: alu_op, a: head.a, b: head.b};
  assign md_req    = '{tag: next_tag, op: md_op_e'(head.funct3), a: head.a, b: head.b};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      next_tag  <= '0;
      in_credit <= 1'b0;
    end else begin
      in_credit <= dispatch;  // one credit back per op leaving the queue
      if (dispatch) begin
        next_tag <= (next_tag == tag_t'(WINDOW - 1)) ? '0 : next_tag + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/alu_lane.sv
`timescale 1ns/10ps
`default_nettype none

module alu_lane import exec_pkg::*; #(
  parameter int LANE_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  alu_req_t req,
  output logic     full,
  output logic     res_valid,
  output result_t  res
);

  alu_req_t    head;
  logic        empty;
  logic        pop;
  logic [4:0]  shamt;
  logic [31:0] value;

  credit_fifo #(.DEPTH(LANE_DEPTH), .item_t(alu_req_t)) u_alu_q (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (push),
    .push_data(req),
    .pop      (pop),
    .pop_data (head),
    .empty    (empty),
    .full     (full)
  );

  assign pop   = !empty;  // single cycle op, never stalls
  assign shamt = head.b[4:0];

  always_comb begin
    value = '0;
    case (head.op)
      ALU_ADD:  value = head.a + head.b;
      ALU_SUB:  value = head.a - head.b;
      ALU_SLL:  value = head.a << shamt;
      ALU_SLT:  value = {31'b0, $signed(head.a) < $signed(head.b)};
      ALU_SLTU: value = {31'b0, head.a < head.b};
      ALU_XOR:  value = head.a ^ head.b;
      ALU_SRL:  value = head.a >> shamt;
      ALU_SRA:  value = $signed(head.a) >>> shamt;  // sign bit fills from the left
      ALU_OR:   value = head.a | head.b;
      ALU_AND:  value = head.a & head.b;
      default:  value = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= pop;
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (pop) begin
      res <= '{tag: head.tag, value: value};
    end
  end

endmodule

`default_nettype wire

//--- logic/muldiv_lane.sv
`timescale 1ns/10ps
`default_nettype none

module muldiv_lane import exec_pkg::*; #(
  parameter int LANE_DEPTH = 4
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    push,
  input  md_req_t req,
  output logic    full,
  output logic    res_valid,
  output result_t res
);

  md_req_t     head;
  logic        empty;
  logic        pop;
  logic        busy;
  logic [4:0]  step_cnt;
  logic        last_step;
  md_op_e      op_q;
  tag_t        tag_q;
  logic        div_q;     // divide family selected
  logic        neg_q;     // negate product or quotient at the end
  logic        neg_r;     // negate remainder at the end
  logic [31:0] m_q;       // multiplicand or divisor magnitude
  logic [31:0] hi_q;
  logic [31:0] lo_q;
  logic        a_neg;
  logic        b_neg;
  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic [32:0] sum;
  logic [32:0] diff;
  logic [31:0] hi_nx;
  logic [31:0] lo_nx;
  logic [63:0] prod_s;
  logic [31:0] value;

  credit_fifo #(.DEPTH(LANE_DEPTH), .item_t(md_req_t)) u_md_q (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (push),
    .push_data(req),
    .pop      (pop),
    .pop_data (head),
    .empty    (empty),
    .full     (full)
  );

  assign pop       = !busy && !empty;
  assign last_step = busy && (step_cnt == 5'd31);

  // operand magnitudes, MUL runs unsigned since its low half is sign-agnostic
  assign a_neg = head.a[31] && (head.op inside {MD_MULH, MD_MULHSU, MD_DIV, MD_REM});
  assign b_neg = head.b[31] && (head.op inside {MD_MULH, MD_DIV, MD_REM});
  assign a_mag = a_neg ? -head.a : head.a;
  assign b_mag = b_neg ? -head.b : head.b;

  assign sum  = {1'b0, hi_q} + {1'b0, m_q};
  assign diff = {hi_q, lo_q[31]} - {1'b0, m_q};  // bit 32 set means borrow

  always_comb begin
    if (div_q) begin
      if (!diff[32]) begin
        hi_nx = diff[31:0];
        lo_nx = {lo_q[30:0], 1'b1};
      end else begin
        hi_nx = {hi_q[30:0], lo_q[31]};
        lo_nx = {lo_q[30:0], 1'b0};
      end
    end else if (lo_q[0]) begin
      {hi_nx, lo_nx} = {sum, lo_q[31:1]};  // add then shift right
    end else begin
      {hi_nx, lo_nx} = {1'b0, hi_q, lo_q[31:1]};
    end
  end

  // sign fix-up folded into the last step
  always_comb begin
    prod_s = neg_q ? -{hi_nx, lo_nx} : {hi_nx, lo_nx};
    case (op_q)
      MD_MUL:                       value = prod_s[31:0];
      MD_MULH, MD_MULHSU, MD_MULHU: value = prod_s[63:32];
      MD_DIV, MD_DIVU:              value = neg_q ? -lo_nx : lo_nx;
      default:                      value = neg_r ? -hi_nx : hi_nx;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      step_cnt  <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= last_step;
      if (pop) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;
        if (last_step) busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      op_q  <= head.op;
      tag_q <= head.tag;
      div_q <= head.op[2];
      // x/0 keeps an all-ones quotient, overflow falls out of the magnitudes
      neg_q <= (a_neg ^ b_neg) && !(head.op[2] && (head.b == '0));
      neg_r <= a_neg;
      m_q   <= head.op[2] ? b_mag : a_mag;
      lo_q  <= head.op[2] ? a_mag : b_mag;
      hi_q  <= '0;
    end else if (busy) begin
      hi_q <= hi_nx;
      lo_q <= lo_nx;
    end
    if (last_step) begin
      res <= '{tag: tag_q, value: value};
    end
  end

endmodule

`default_nettype wire

//--- logic/retire_merge.sv
`timescale 1ns/10ps
`default_nettype none

module retire_merge import exec_pkg::*; #(
  parameter int WINDOW = 8
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    alloc,
  input  tag_t    alloc_tag,
  output logic    slot_free,
  input  logic    alu_valid,
  input  result_t alu_res,
  input  logic    md_valid,
  input  result_t md_res,
  input  logic    out_credit,
  output logic    out_valid,
  output result_t out_res
);

  localparam int IW = $clog2(WINDOW);

  logic [WINDOW-1:0] busy;
  logic [WINDOW-1:0] done;
  logic [31:0]       values [WINDOW];
  logic [IW-1:0]     head;
  logic [IW-1:0]     alloc_cnt;   // mirrors the router's next tag
  logic [31:0]       credit_cnt;
  logic              emit;

  assign slot_free = !busy[alloc_cnt];

  // oldest slot leaves once written and a downstream credit is held
  assign emit      = busy[head] && done[head] && (credit_cnt != '0);
  assign out_valid = emit;
  assign out_res   = '{tag: tag_t'(head), value: values[head]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy       <= '0;
      done       <= '0;
      head       <= '0;
      alloc_cnt  <= '0;
      credit_cnt <= '0;
    end else begin
      credit_cnt <= credit_cnt + 32'(out_credit) - 32'(emit);
      if (alloc) begin
        busy[alloc_tag[IW-1:0]] <= 1'b1;
        done[alloc_tag[IW-1:0]] <= 1'b0;
        alloc_cnt <= alloc_cnt + 1'b1;
      end
      // lane tags always differ, both may land here together
      if (alu_valid) done[alu_res.tag[IW-1:0]] <= 1'b1;
      if (md_valid) done[md_res.tag[IW-1:0]] <= 1'b1;
      if (emit) begin
        busy[head] <= 1'b0;
        done[head] <= 1'b0;
        head       <= head + 1'b1;  // wraps at WINDOW
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alu_valid) begin
      values[alu_res.tag[IW-1:0]] <= alu_res.value;
    end
    if (md_valid) begin
      values[md_res.tag[IW-1:0]] <= md_res.value;
    end
  end

endmodule

`default_nettype wire

//--- logic/exec_cluster.sv
`timescale 1ns/10ps
`default_nettype none

module exec_cluster import exec_pkg::*; #(
  parameter int IN_DEPTH   = 4,
  parameter int LANE_DEPTH = 4,
  parameter int WINDOW     = 8
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  input  issue_t  in_op,
  output logic    in_credit,
  input  logic    out_credit,
  output logic    out_valid,
  output result_t out_res
);

  logic     slot_free;
  logic     alloc;
  tag_t     alloc_tag;
  logic     alu_push;
  alu_req_t alu_req;
  logic     alu_full;
  logic     md_push;
  md_req_t  md_req;
  logic     md_full;
  logic     alu_valid;
  result_t  alu_res;
  logic     md_valid;
  result_t  md_res;

  issue_router #(.IN_DEPTH(IN_DEPTH), .WINDOW(WINDOW)) u_router (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_credit(in_credit),
    .slot_free(slot_free),
    .alloc    (alloc),
    .alloc_tag(alloc_tag),
    .alu_push (alu_push),
    .alu_req  (alu_req),
    .alu_full (alu_full),
    .md_push  (md_push),
    .md_req   (md_req),
    .md_full  (md_full)
  );

  alu_lane #(.LANE_DEPTH(LANE_DEPTH)) u_alu (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (alu_push),
    .req      (alu_req),
    .full     (alu_full),
    .res_valid(alu_valid),
    .res      (alu_res)
  );

  // iterative lane, 33 cycles per op
  muldiv_lane #(.LANE_DEPTH(LANE_DEPTH)) u_muldiv (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (md_push),
    .req      (md_req),
    .full     (md_full),
    .res_valid(md_valid),
    .res      (md_res)
  );

  retire_merge #(.WINDOW(WINDOW)) u_merge (
    .clk       (clk),
    .rst_n     (rst_n),
    .alloc     (alloc),
    .alloc_tag (alloc_tag),
    .slot_free (slot_free),
    .alu_valid (alu_valid),
    .alu_res   (alu_res),
    .md_valid  (md_valid),
    .md_res    (md_res),
    .out_credit(out_credit),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

endmodule

`default_nettype wire

//--- verification/exec_cluster_properties.sv
`timescale 1ns/10ps
`default_nettype none

module exec_cluster_properties import exec_pkg::*; #(
  parameter int WINDOW = 8
) (
  input logic              clk,
  input logic              rst_n,
  input logic              in_valid,
  input logic              issue_full,
  input logic              alu_push,
  input logic              alu_full,
  input logic              md_push,
  input logic              md_full,
  input logic              alloc,
  input tag_t              alloc_tag,
  input logic [WINDOW-1:0] slot_busy,
  input logic              out_valid,
  input logic [31:0]       credit_cnt
);

  localparam int IW = $clog2(WINDOW);

  int assert_fails = 0;  // read back by the testbench at the end

  // upstream sends only against a credit
  a_issue_room: assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> !issue_full)
    else begin
      $error("issue queue pushed while full");
      assert_fails++;
    end

  a_alu_room: assert property (@(posedge clk) disable iff (!rst_n) alu_push |-> !alu_full)
    else begin
      $error("ALU lane queue pushed while full");
      assert_fails++;
    end

  a_md_room: assert property (@(posedge clk) disable iff (!rst_n) md_push |-> !md_full)
    else begin
      $error("mul/div lane queue pushed while full");
      assert_fails++;
    end

  a_out_credit: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> credit_cnt != 0)
    else begin
      $error("result emitted without an output credit");
      assert_fails++;
    end

  a_slot_idle: assert property (@(posedge clk) disable iff (!rst_n)
                                alloc |-> !slot_busy[alloc_tag[IW-1:0]])
    else begin
      $error("reorder slot allocated while busy");
      assert_fails++;
    end

endmodule

bind exec_cluster exec_cluster_properties #(.WINDOW(WINDOW)) u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .issue_full(u_router.full),
  .alu_push  (alu_push),
  .alu_full  (alu_full),
  .md_push   (md_push),
  .md_full   (md_full),
  .alloc     (alloc),
  .alloc_tag (alloc_tag),
  .slot_busy (u_merge.busy),
  .out_valid (out_valid),
  .credit_cnt(u_merge.credit_cnt)
);

`default_nettype wire

//--- verification/exec_cluster_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exec_cluster_tb import exec_pkg::*; ();

  localparam int IN_DEPTH     = 4;
  localparam int LANE_DEPTH   = 4;
  localparam int WINDOW       = 8;
  localparam int RESET_CYCLES = 8;
  localparam int MIXED_OPS    = 200;
  localparam int STALL_OPS    = 40;

  typedef enum logic [1:0] {CREDIT_FREE, CREDIT_HOLD, CREDIT_BURST} credit_mode_e;

  logic    clk;
  logic    rst_n;
  logic    in_valid;
  issue_t  in_op;
  logic    in_credit;
  logic    out_credit;
  logic    out_valid;
  result_t out_res;

  credit_mode_e credit_mode;
  result_t      exp_q [$];          // expected results in issue order
  int           sent_cnt        = 0;
  int           accepted_cnt    = 0;  // ops taken in by the DUT
  int           in_credit_cnt   = 0;
  int           grant_cnt       = 0;  // output credits handed to the DUT
  int           out_done_cnt    = 0;
  int           burst_phase     = 0;
  int           error_cnt       = 0;
  int           check_cnt       = 0;
  int           test_cnt        = 0;
  int           test_err_base   = 0;

  exec_cluster #(.IN_DEPTH(IN_DEPTH), .LANE_DEPTH(LANE_DEPTH), .WINDOW(WINDOW)) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_credit (in_credit),
    .out_credit(out_credit),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    check_cnt++;
    if (got !== want) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
      error_cnt++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%0t: %s", $time, msg);
    error_cnt++;
  endtask

  task automatic start_test();
    test_err_base = error_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (error_cnt == test_err_base) $display("test %s: passed", name);
    else $display("test %s: failed with %0d errors", name, error_cnt - test_err_base);
  endtask

  // RV32IM result straight from the ISA rules
  function automatic logic [31:0] expected_result(input issue_t op);
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] prod;
    logic        alt;
    a    = op.a;
    b    = op.b;
    alt  = (op.funct7 == 7'b0100000);
    prod = '0;
    if (op.funct7 == 7'b0000001) begin
      case (op.funct3)
        3'b010:  prod = {{32{a[31]}}, a} * {32'b0, b};  // signed times unsigned
        3'b011:  prod = {32'b0, a} * {32'b0, b};
        default: prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      endcase
      case (op.funct3)
        3'b000: return prod[31:0];
        3'b100: begin
          if (b == '0) return 32'hffff_ffff;
          if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
          return $signed(a) / $signed(b);
        end
        3'b101: return (b == '0) ? 32'hffff_ffff : a / b;
        3'b110: begin
          if (b == '0) return a;
          if (a == 32'h8000_0000 && b == 32'hffff_ffff) return '0;
          return $signed(a) % $signed(b);  // sign follows the dividend
        end
        3'b111: return (b == '0) ? a : a % b;
        default: return prod[63:32];
      endcase
    end
    case (op.funct3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic issue_t make_op(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [31:0] a, input logic [31:0] b);
    return '{funct7: f7, funct3: f3, a: a, b: b};
  endfunction

  function automatic issue_t random_op();
    issue_t     op;
    logic [2:0] kind;
    kind      = 3'($urandom_range(0, 7));
    op.funct3 = 3'($urandom);
    op.a      = $urandom;
    op.b      = $urandom;
    case (kind)
      0, 1, 2: op.funct7 = 7'b0000001;
      3:       op.funct7 = 7'b0100000;
      4:       op.funct7 = 7'($urandom);  // any encoding, mostly base ops
      default: op.funct7 = 7'b0000000;
    endcase
    if ($urandom_range(0, 15) == 0) op.b = '0;
    return op;
  endfunction

  // one op per edge, only while an upstream credit is held
  task automatic send_op(input issue_t op);
    @(posedge clk);
    while (sent_cnt - in_credit_cnt >= IN_DEPTH) begin
      in_valid <= 1'b0;
      @(posedge clk);
    end
    in_valid <= 1'b1;
    in_op    <= op;
    exp_q.push_back('{tag: tag_t'(sent_cnt % WINDOW), value: expected_result(op)});
    sent_cnt++;
  endtask

  task automatic wait_drain();
    @(posedge clk);
    in_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic run_alu_pair(input logic [31:0] a, input logic [31:0] b);
    int f3;
    for (f3 = 0; f3 < 8; f3++) begin
      send_op(make_op(7'b0000000, 3'(f3), a, b));
    end
    send_op(make_op(7'b0100000, 3'b000, a, b));  // SUB
    send_op(make_op(7'b0100000, 3'b101, a, b));  // SRA
    send_op(make_op(7'b0100000, 3'b010, a, b));
    send_op(make_op(7'b0010000, 3'b000, a, b));  // odd funct7 falls back to ADD
    send_op(make_op(7'b1111111, 3'b101, a, b));
  endtask

  task automatic run_md_pair(input logic [31:0] a, input logic [31:0] b);
    int f3;
    for (f3 = 0; f3 < 8; f3++) begin
      send_op(make_op(7'b0000001, 3'(f3), a, b));
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      out_credit <= 1'b0;
    end else begin
      case (credit_mode)
        CREDIT_FREE:  out_credit <= (grant_cnt - out_done_cnt) < 2;  // keep a small balance
        CREDIT_BURST: out_credit <= (burst_phase % 24) < 6;
        default:      out_credit <= 1'b0;
      endcase
      burst_phase <= burst_phase + 1;
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (in_valid) accepted_cnt <= accepted_cnt + 1;
      if (in_credit) begin
        if (in_credit_cnt >= accepted_cnt) begin
          note_failure("in_credit pulsed with no operation queued");
        end
        in_credit_cnt <= in_credit_cnt + 1;
      end
      if (out_credit) grant_cnt <= grant_cnt + 1;
      if (out_valid) out_done_cnt <= out_done_cnt + 1;
    end
  end

  // compare each result against the head of the expected queue
  always @(posedge clk) begin
    result_t expected;
    if (rst_n && out_valid) begin
      if (grant_cnt <= out_done_cnt) note_failure("out_valid raised beyond the credits granted");
      if (exp_q.size() == 0) begin
        note_failure("result arrived with no operation pending");
      end else begin
        expected = exp_q.pop_front();
        check_value("out_res.value", out_res.value, expected.value);
        check_value("out_res.tag", 32'(out_res.tag), 32'(expected.tag));
      end
    end
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles <= 200 * sent_cnt + 1000) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles with %0d ops sent", cycles, sent_cnt);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int i;
    int stalled_pulses;
    int total_errors;
    void'($urandom(32'hc96a_9c97));
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_op       = '0;
    out_credit  = 1'b0;
    credit_mode = CREDIT_HOLD;

    start_test();
    @(posedge clk);  // first edge loads the reset values
    for (i = 1; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      check_value("out_valid", out_valid, 1'b0);
      check_value("in_credit", in_credit, 1'b0);
    end
    rst_n       <= 1'b1;
    credit_mode <= CREDIT_FREE;
    repeat (10) begin
      @(posedge clk);
      check_value("out_valid", out_valid, 1'b0);
      check_value("in_credit", in_credit, 1'b0);
    end
    end_test("reset");

    start_test();
    run_alu_pair(32'h0000_1234, 32'h0000_0005);
    run_alu_pair(32'hffff_fff0, 32'h0000_0004);  // negative for SRA and SLT
    run_alu_pair(32'h8000_0001, 32'hffff_ffff);
    run_alu_pair(32'h0000_0003, 32'hffff_fffd);
    wait_drain();
    end_test("alu ops");

    start_test();
    run_md_pair(32'h0001_2345, 32'h0000_0067);
    run_md_pair(32'hffff_fff9, 32'h0000_0002);
    run_md_pair(32'h0000_0007, 32'hffff_fffe);
    run_md_pair(32'h8000_0000, 32'hffff_ffff);  // signed overflow
    run_md_pair(32'hdead_beef, 32'h0000_0000);  // divide by zero
    run_md_pair(32'h8000_0000, 32'h8000_0000);
    wait_drain();
    end_test("muldiv ops");

    start_test();
    for (i = 0; i < MIXED_OPS; i++) begin
      send_op(random_op());
    end
    wait_drain();
    end_test("mixed stream");

    start_test();
    @(posedge clk);
    credit_mode <= CREDIT_HOLD;
    fork
      for (i = 0; i < STALL_OPS; i++) begin
        send_op(random_op());
      end
      begin
        repeat (500) @(posedge clk);
        stalled_pulses = in_credit_cnt;
        repeat (100) @(posedge clk);
        check_value("in_credit pulses while stalled", in_credit_cnt, stalled_pulses);
        credit_mode <= CREDIT_BURST;
      end
    join
    wait_drain();
    end_test("back-pressure");

    start_test();
    repeat (4) @(posedge clk);
    check_value("in_credit pulse count", in_credit_cnt, sent_cnt);
    end_test("input credits");

    total_errors = error_cnt + uut.u_props.assert_fails;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             test_cnt, check_cnt, error_cnt, uut.u_props.assert_fails);
    if (total_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- exec_cluster.f
logic/exec_pkg.sv
logic/credit_fifo.sv
logic/issue_router.sv
logic/alu_lane.sv
logic/muldiv_lane.sv
logic/retire_merge.sv
logic/exec_cluster.sv
verification/exec_cluster_properties.sv
verification/exec_cluster_tb.sv

//--- Bender.yml
package:
  name: exec_cluster

sources:
  - logic/exec_pkg.sv
  - logic/credit_fifo.sv
  - logic/issue_router.sv
  - logic/alu_lane.sv
  - logic/muldiv_lane.sv
  - logic/retire_merge.sv
  - logic/exec_cluster.sv
  - target: simulation
    files:
      - verification/exec_cluster_properties.sv
      - verification/exec_cluster_tb.sv
